/* vlog.f */
+incdir+hw
hw/cpu_isa_pkg.sv
hw/cpu_bus_pkg.sv
hw/cpu_state_bank.sv
hw/cpu_alu.sv
hw/cpu_control.sv
hw/cpu_apb_requester.sv
hw/cpu_top.sv
dv/cpu_tb_memory.sv
dv/cpu_tb.sv

/* dv/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_tb;

    localparam int RESET_CYCLES      = 16;
    localparam int PROGRAM_LENGTH    = 30;
    localparam int CYCLE_LIMIT       = PROGRAM_LENGTH * 12 + RESET_CYCLES;
    localparam int HALT_WATCH_CYCLES = 40;
    localparam int TEST_COUNT        = 6;

    localparam logic [15:0]        IMM_LO      = 16'h1234;
    localparam logic [15:0]        IMM_HI      = 16'habcd;
    localparam cpu_isa_pkg::word_t VALUE_B     = 32'h0000_00f0;
    localparam cpu_isa_pkg::word_t VALUE_C     = 32'h0000_0f3c;
    localparam cpu_isa_pkg::word_t POISON      = 32'h0000_dead;
    localparam cpu_isa_pkg::word_t DATA_BASE   = 32'h0000_0100;
    localparam cpu_isa_pkg::word_t POISON_BASE = 32'h0000_01f0;

    logic               clock;
    logic               reset;
    cpu_isa_pkg::word_t paddr;
    cpu_isa_pkg::word_t pwdata;
    cpu_isa_pkg::word_t prdata;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic               pready;
    logic               halted;
    logic [1:0]         wait_draw;
    logic               write_strobe;
    cpu_isa_pkg::word_t write_addr;
    cpu_isa_pkg::word_t write_data;

    cpu_isa_pkg::word_t program_words [PROGRAM_LENGTH];
    bit                 never_fetched [PROGRAM_LENGTH];
    cpu_isa_pkg::word_t exp_fetch [PROGRAM_LENGTH];
    cpu_isa_pkg::word_t exp_addr [PROGRAM_LENGTH];
    cpu_isa_pkg::word_t exp_data [PROGRAM_LENGTH];
    int                 program_size;
    int                 poison_count;
    int                 halt_index;
    int                 n_fetch;
    int                 n_stores;
    int                 fetch_count;
    int                 store_count;
    int                 cycle_count;
    int                 errors [1:TEST_COUNT];
    int                 clean_tests;
    int                 failure_total;

    cpu_top u_dut (
        .clock(clock), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready), .halted(halted)
    );

    cpu_tb_memory u_memory (
        .clock(clock), .reset(reset), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready),
        .wait_draw(wait_draw), .write_strobe(write_strobe),
        .write_addr(write_addr), .write_data(write_data)
    );

    // bits 31:16 imm, 15 high, 14:12 dest, 11:9 source b, 8:6 source a, 5:0 opcode
    function automatic cpu_isa_pkg::word_t encode(cpu_isa_pkg::opcode_e op, int dest,
                                                  int src_a, int src_b, logic high,
                                                  logic [15:0] imm);
        return {imm, high, dest[2:0], src_b[2:0], src_a[2:0], op};
    endfunction

    function automatic cpu_isa_pkg::word_t addr_of(int index);
        return cpu_isa_pkg::word_t'(`CPU_RESET_PC) + cpu_isa_pkg::word_t'(index * 4);
    endfunction

    task automatic put(cpu_isa_pkg::opcode_e op, int dest, int src_a, int src_b,
                       logic high, logic [15:0] imm);
        if (op == cpu_isa_pkg::op_halt)
            halt_index = program_size;
        program_words[program_size] = encode(op, dest, src_a, src_b, high, imm);
        program_size++;
    endtask

    task automatic put_redirect(cpu_isa_pkg::opcode_e op, int flag, int target_index);
        cpu_isa_pkg::word_t target;
        target = addr_of(target_index);
        put(op, 0, flag, 0, 1'b0, target[15:0]);
    endtask

    task automatic store_checked(int src, cpu_isa_pkg::word_t value);
        cpu_isa_pkg::word_t addr;
        addr = DATA_BASE + cpu_isa_pkg::word_t'(n_stores * 4);
        exp_addr[n_stores] = addr;
        exp_data[n_stores] = value;
        n_stores++;
        put(cpu_isa_pkg::op_store, 0, src, 0, 1'b0, addr[15:0]);
    endtask

    // control flow must always pass over this store
    task automatic store_poison(int src);
        cpu_isa_pkg::word_t addr;
        addr = POISON_BASE + cpu_isa_pkg::word_t'(poison_count * 4);
        poison_count++;
        never_fetched[program_size] = 1'b1;
        put(cpu_isa_pkg::op_store, 0, src, 0, 1'b0, addr[15:0]);
    endtask

    task automatic build_program();
        cpu_isa_pkg::word_t both_halves;
        both_halves = {IMM_HI, IMM_LO};
        put(cpu_isa_pkg::op_ldi, 1, 0, 0, 1'b0, IMM_LO);
        put(cpu_isa_pkg::op_ldi, 1, 1, 0, 1'b1, IMM_HI);
        store_checked(1, both_halves);
        put(cpu_isa_pkg::op_ldi, 2, 0, 0, 1'b0, VALUE_B[15:0]);
        put(cpu_isa_pkg::op_ldi, 3, 0, 0, 1'b0, VALUE_C[15:0]);
        put(cpu_isa_pkg::op_ldi, 6, 0, 0, 1'b0, POISON[15:0]);
        put(cpu_isa_pkg::op_add, 4, 2, 3, 1'b0, 16'h0);
        store_checked(4, VALUE_B + VALUE_C);
        put(cpu_isa_pkg::op_sub, 4, 2, 3, 1'b0, 16'h0);
        store_checked(4, VALUE_B - VALUE_C);
        put(cpu_isa_pkg::op_and, 4, 1, 3, 1'b0, 16'h0);
        store_checked(4, both_halves & VALUE_C);
        put(cpu_isa_pkg::op_or, 4, 1, 2, 1'b0, 16'h0);
        store_checked(4, both_halves | VALUE_B);
        // zero result sets flag 5, so the branch skips the poison
        put(cpu_isa_pkg::op_xor, 5, 2, 2, 1'b0, 16'h0);
        put_redirect(cpu_isa_pkg::op_branch, 5, 17);
        store_poison(6);
        store_checked(5, VALUE_B ^ VALUE_B);
        put(cpu_isa_pkg::op_cmpeq, 7, 2, 3, 1'b0, 16'h0);
        put_redirect(cpu_isa_pkg::op_branch, 7, 21);
        store_checked(3, VALUE_C);
        put(cpu_isa_pkg::op_cmpeq, 0, 3, 3, 1'b0, 16'h0);
        put_redirect(cpu_isa_pkg::op_branch, 0, 24);
        store_poison(6);
        store_checked(2, VALUE_B);
        put_redirect(cpu_isa_pkg::op_jump, 0, 27);
        store_poison(6);
        store_checked(1, both_halves);
        put(cpu_isa_pkg::op_halt, 0, 0, 0, 1'b0, 16'h0);
        store_poison(6);
        for (int i = 0; i <= halt_index; i++)
        begin
            if (!never_fetched[i])
            begin
                exp_fetch[n_fetch] = addr_of(i);
                n_fetch++;
            end
        end
    endtask

    task automatic record_failure(int test, string message);
        errors[test]++;
        $display("FAILED at %0t: %s", $time, message);
    endtask

    task automatic report_test(int test, string name);
        if (errors[test] == 0)
        begin
            clean_tests++;
            $display("test %0d %s: passed", test, name);
        end
        else
            $display("test %0d %s: %0d failures", test, name, errors[test]);
    endtask

    initial
    begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial
    begin
        void'($urandom(32'hfc0fbf01));
        reset     = 1'b1;
        wait_draw = 2'd0;
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        forever
        begin
            @(negedge clock);
            wait_draw = 2'($urandom % 4);
        end
    end

    always @(posedge clock)
    begin
        cycle_count <= cycle_count + 1;
        if (reset)
        begin
            fetch_count <= 0;
            store_count <= 0;
        end
        else
        begin
            if (psel && penable && pready && !pwrite)
                fetch_count <= fetch_count + 1;
            if (write_strobe)
                store_count <= store_count + 1;
        end
        if (cycle_count >= CYCLE_LIMIT)
        begin
            $display("timeout: the core did not halt within %0d cycles", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    a_reset_quiet: assert property (@(posedge clock)
        (reset && cycle_count > 0) |-> (!psel && !penable && !halted))
        else record_failure(1, "bus or halted active during reset");

    a_fetch_order: assert property (@(posedge clock) disable iff (reset)
        (psel && !penable && !pwrite) |->
            (fetch_count < n_fetch && paddr == exp_fetch[fetch_count]))
        else record_failure(1, $sformatf("fetch at %h out of program order", $sampled(paddr)));

    a_store_ldi: assert property (@(posedge clock) disable iff (reset)
        (write_strobe && store_count == 0) |->
            (write_addr == exp_addr[0] && write_data == exp_data[0]))
        else record_failure(3, $sformatf("load immediate store wrote %h", $sampled(write_data)));

    a_store_alu: assert property (@(posedge clock) disable iff (reset)
        (write_strobe && store_count >= 1 && store_count <= 5) |->
            (write_addr == exp_addr[store_count] && write_data == exp_data[store_count]))
        else record_failure(2, $sformatf("alu store wrote %h at %h",
                                         $sampled(write_data), $sampled(write_addr)));

    a_store_flow: assert property (@(posedge clock) disable iff (reset)
        (write_strobe && store_count >= 6) |-> (store_count < n_stores &&
            write_addr == exp_addr[store_count] && write_data == exp_data[store_count]))
        else record_failure(4, $sformatf("flow store wrote %h at %h",
                                         $sampled(write_data), $sampled(write_addr)));

    a_no_poison: assert property (@(posedge clock) disable iff (reset)
        write_strobe |-> (write_data != POISON))
        else record_failure(4, "a skipped store wrote the poison value");

    a_enable_has_select: assert property (@(posedge clock) disable iff (reset)
        penable |-> psel)
        else record_failure(5, "penable high without psel");

    a_setup_then_access: assert property (@(posedge clock) disable iff (reset)
        (psel && !penable) |=>
            (psel && penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata)))
        else record_failure(5, "setup not followed by a matching access");

    a_held_until_ready: assert property (@(posedge clock) disable iff (reset)
        (psel && penable && !pready) |=>
            (psel && penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata)))
        else record_failure(5, "transfer changed while waiting for pready");

    a_halt_sticky: assert property (@(posedge clock) disable iff (reset)
        halted |=> halted)
        else record_failure(6, "halted dropped");

    a_quiet_after_halt: assert property (@(posedge clock) disable iff (reset)
        halted |-> !psel)
        else record_failure(6, "bus transfer started after halt");

    a_halt_last: assert property (@(posedge clock) disable iff (reset)
        $rose(halted) |-> (store_count == n_stores && fetch_count == n_fetch))
        else record_failure(6, "halt before the whole program ran");

    initial
    begin
        // memory fills itself at time zero, the program goes in afterwards
        @(negedge clock);
        build_program();
        for (int i = 0; i < program_size; i++)
            u_memory.mem[(`CPU_RESET_PC >> 2) + i] = program_words[i];
        wait (store_count >= 1);
        @(negedge clock);
        report_test(3, "load immediate forms");
        wait (store_count >= 6);
        @(negedge clock);
        report_test(2, "arithmetic and logic");
        wait (store_count >= n_stores);
        @(negedge clock);
        report_test(4, "compare, branch and jump");
        wait (fetch_count >= n_fetch);
        @(negedge clock);
        report_test(1, "reset and fetch order");
        wait (halted);
        @(negedge clock);
        report_test(5, "apb protocol under wait states");
        repeat (HALT_WATCH_CYCLES) @(negedge clock);
        report_test(6, "halt");
        for (int t = 1; t <= TEST_COUNT; t++)
            failure_total += errors[t];
        $display("summary: %0d of %0d tests clean, %0d check failures",
                 clean_tests, TEST_COUNT, failure_total);
        if (failure_total == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* dv/cpu_tb_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_tb_memory #(
    parameter int MEM_WORDS = 128
) (
    input  wire                     clock,
    input  wire                     reset,
    input  wire cpu_isa_pkg::word_t paddr,
    input  wire                     psel,
    input  wire                     penable,
    input  wire                     pwrite,
    input  wire cpu_isa_pkg::word_t pwdata,
    output cpu_isa_pkg::word_t      prdata,
    output logic                    pready,
    input  wire [1:0]               wait_draw,
    output logic                    write_strobe,
    output cpu_isa_pkg::word_t      write_addr,
    output cpu_isa_pkg::word_t      write_data
);

    localparam int INDEX_BITS = $clog2(MEM_WORDS);

    cpu_isa_pkg::word_t      mem [MEM_WORDS];
    cpu_bus_pkg::apb_phase_e seen_phase;
    logic [1:0]              wait_left;
    logic [INDEX_BITS-1:0]   index;

    assign index = paddr[INDEX_BITS+1:2];

    always_comb
    begin
        if (psel && penable)
            seen_phase = cpu_bus_pkg::apb_access;
        else if (psel)
            seen_phase = cpu_bus_pkg::apb_setup;
        else
            seen_phase = cpu_bus_pkg::apb_idle;
    end

    // unused words hold a pattern of their own byte address
    initial
    begin
        pready       = 1'b0;
        prdata       = '0;
        write_strobe = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = 32'hc3c3_0000 ^ cpu_isa_pkg::word_t'(i * 4);
    end

    // wait count is taken at the end of setup, writes land at completion
    always @(posedge clock)
    begin
        if (reset)
        begin
            wait_left    <= 2'd0;
            write_strobe <= 1'b0;
        end
        else
        begin
            write_strobe <= 1'b0;
            if (seen_phase == cpu_bus_pkg::apb_setup)
                wait_left <= wait_draw;
            else if (seen_phase == cpu_bus_pkg::apb_access && !pready)
                wait_left <= wait_left - 2'd1;
            else if (seen_phase == cpu_bus_pkg::apb_access && pwrite)
            begin
                mem[index]   <= pwdata;
                write_strobe <= 1'b1;
                write_addr   <= paddr;
                write_data   <= pwdata;
            end
        end
    end

    always @(negedge clock)
    begin
        if (!reset && seen_phase == cpu_bus_pkg::apb_access && wait_left == 2'd0)
        begin
            pready <= 1'b1;
            prdata <= mem[index];
        end
        else
            pready <= 1'b0;
    end

endmodule

`default_nettype wire

/* hw/cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  wire                     clock,
    input  wire                     reset,

    output cpu_isa_pkg::word_t      paddr,
    output logic                    psel,
    output logic                    penable,
    output logic                    pwrite,
    output cpu_isa_pkg::word_t      pwdata,
    input  wire cpu_isa_pkg::word_t prdata,
    input  wire                     pready,

    output logic                    halted
);

    cpu_isa_pkg::word_t    alu_instr;
    cpu_isa_pkg::instr_t   instr_fields;
    cpu_isa_pkg::word_t    src_a;
    cpu_isa_pkg::word_t    src_b;
    cpu_isa_pkg::flag_t    flag_a;
    cpu_isa_pkg::flag_t    flag_b;
    cpu_isa_pkg::word_t    result;
    cpu_isa_pkg::flag_t    result_flag;
    logic                  write_reg;
    logic                  write_flag;
    logic                  redirect;
    cpu_isa_pkg::word_t    target;
    logic                  store_req;
    logic                  halt_req;
    logic                  reg_wr_enable;
    logic                  flag_wr_enable;
    logic                  req_valid;
    cpu_bus_pkg::request_e req_kind;
    cpu_isa_pkg::word_t    req_addr;
    cpu_isa_pkg::word_t    req_wdata;
    logic                  req_done;
    cpu_isa_pkg::word_t    rsp_data;

    // field view of the instruction register for the bank indices
    assign instr_fields = cpu_isa_pkg::instr_t'(alu_instr);

    cpu_state_bank #(.entry_t(cpu_isa_pkg::word_t)) u_reg_bank (
        .clock(clock), .reset(reset),
        .rd_index_a(instr_fields.src_a), .rd_data_a(src_a),
        .rd_index_b(instr_fields.src_b), .rd_data_b(src_b),
        .wr_enable(reg_wr_enable), .wr_index(instr_fields.dest), .wr_data(result)
    );

    cpu_state_bank #(.entry_t(cpu_isa_pkg::flag_t)) u_flag_bank (
        .clock(clock), .reset(reset),
        .rd_index_a(instr_fields.src_a), .rd_data_a(flag_a),
        .rd_index_b(instr_fields.src_b), .rd_data_b(flag_b),
        .wr_enable(flag_wr_enable), .wr_index(instr_fields.dest), .wr_data(result_flag)
    );

    cpu_alu u_alu (
        .instr(alu_instr), .src_a(src_a), .src_b(src_b), .flag_a(flag_a), .flag_b(flag_b),
        .result(result), .result_flag(result_flag),
        .write_reg(write_reg), .write_flag(write_flag),
        .redirect(redirect), .target(target), .store_req(store_req), .halt_req(halt_req)
    );

    cpu_control u_control (
        .clock(clock), .reset(reset), .alu_instr(alu_instr),
        .write_reg(write_reg), .write_flag(write_flag), .redirect(redirect),
        .target(target), .store_req(store_req), .halt_req(halt_req),
        .reg_wr_enable(reg_wr_enable), .flag_wr_enable(flag_wr_enable),
        .store_data(src_a),
        .req_valid(req_valid), .req_kind(req_kind), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_done(req_done), .rsp_data(rsp_data),
        .halted(halted)
    );

    cpu_apb_requester u_apb_requester (
        .clock(clock), .reset(reset),
        .req_valid(req_valid), .req_kind(req_kind), .req_addr(req_addr),
        .req_wdata(req_wdata), .req_done(req_done), .rsp_data(rsp_data),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready)
    );

endmodule

`default_nettype wire

/* hw/cpu_apb_requester.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_apb_requester (
    input  wire                       clock,
    input  wire                       reset,

    input  wire                       req_valid,
    input  wire cpu_bus_pkg::request_e req_kind,
    input  wire cpu_isa_pkg::word_t   req_addr,
    input  wire cpu_isa_pkg::word_t   req_wdata,
    output logic                      req_done,
    output cpu_isa_pkg::word_t        rsp_data,

    output cpu_isa_pkg::word_t        paddr,
    output logic                      psel,
    output logic                      penable,
    output logic                      pwrite,
    output cpu_isa_pkg::word_t        pwdata,
    input  wire cpu_isa_pkg::word_t   prdata,
    input  wire                       pready
);

    // registered state holds only idle or access
    cpu_bus_pkg::apb_phase_e phase_q;
    cpu_bus_pkg::apb_phase_e bus_phase;

    cpu_isa_pkg::word_t addr_q;
    cpu_isa_pkg::word_t wdata_q;
    logic               write_q;

    // setup is the cycle a request is first seen
    always_comb
    begin
        if (phase_q == cpu_bus_pkg::apb_access)
            bus_phase = cpu_bus_pkg::apb_access;
        else if (req_valid)
            bus_phase = cpu_bus_pkg::apb_setup;
        else
            bus_phase = cpu_bus_pkg::apb_idle;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            phase_q <= cpu_bus_pkg::apb_idle;
        else if (bus_phase == cpu_bus_pkg::apb_setup)
            phase_q <= cpu_bus_pkg::apb_access;
        else if (req_done)
            phase_q <= cpu_bus_pkg::apb_idle;
    end

    always_ff @(posedge clock)
    begin
        if (bus_phase == cpu_bus_pkg::apb_setup)
        begin
            addr_q  <= req_addr;
            wdata_q <= req_wdata;
            write_q <= (req_kind == cpu_bus_pkg::req_store);
        end
    end

    assign psel    = (bus_phase != cpu_bus_pkg::apb_idle);
    assign penable = (bus_phase == cpu_bus_pkg::apb_access);
    assign paddr   = penable ? addr_q : req_addr;
    assign pwdata  = penable ? wdata_q : req_wdata;
    assign pwrite  = penable ? write_q : (req_valid && req_kind == cpu_bus_pkg::req_store);

    assign req_done = penable && pready;
    assign rsp_data = prdata;

    a_enable_needs_select: assert property (
        @(posedge clock) disable iff (reset)
        penable |-> psel
    )
    else
        $error("penable without psel");

    // setup always moves to access, and access holds until pready
    a_transfer_held: assert property (
        @(posedge clock) disable iff (reset)
        (psel && !(penable && pready)) |=>
            (psel && penable && $stable(paddr) && $stable(pwrite) && $stable(pwdata))
    )
    else
        $error("apb transfer changed before completion");

endmodule

`default_nettype wire

/* hw/cpu_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_control (
    input  wire                    clock,
    input  wire                    reset,

    output cpu_isa_pkg::word_t     alu_instr,

    input  wire                    write_reg,
    input  wire                    write_flag,
    input  wire                    redirect,
    input  wire cpu_isa_pkg::word_t target,
    input  wire                    store_req,
    input  wire                    halt_req,

    output logic                   reg_wr_enable,
    output logic                   flag_wr_enable,

    input  wire cpu_isa_pkg::word_t store_data,

    output logic                   req_valid,
    output cpu_bus_pkg::request_e  req_kind,
    output cpu_isa_pkg::word_t     req_addr,
    output cpu_isa_pkg::word_t     req_wdata,
    input  wire                    req_done,
    input  wire cpu_isa_pkg::word_t rsp_data,

    output logic                   halted
);

    // idle only lasts the cycle after reset, so psel stays low in reset
    typedef enum logic [2:0] {
        ph_idle,
        ph_fetch,
        ph_execute,
        ph_store,
        ph_halted
    } phase_e;

    phase_e             phase;
    cpu_isa_pkg::word_t instr_q;
    cpu_isa_pkg::word_t pc;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            phase <= ph_idle;
            pc    <= cpu_isa_pkg::word_t'(`CPU_RESET_PC);
        end
        else
        begin
            case (phase)
                ph_idle: phase <= ph_fetch;
                ph_fetch:
                begin
                    if (req_done)
                        phase <= ph_execute;
                end
                ph_execute:
                begin
                    pc <= redirect ? target : pc + cpu_isa_pkg::word_t'(4);
                    if (halt_req)
                        phase <= ph_halted;
                    else if (store_req)
                        phase <= ph_store;
                    else
                        phase <= ph_fetch;
                end
                ph_store:
                begin
                    if (req_done)
                        phase <= ph_fetch;
                end
                ph_halted: phase <= ph_halted;
                default:   phase <= ph_idle;
            endcase
        end
    end

    // instruction register
    always_ff @(posedge clock)
    begin
        if (phase == ph_fetch && req_done)
            instr_q <= rsp_data;
    end

    assign alu_instr = instr_q;

    assign reg_wr_enable  = write_reg && (phase == ph_execute);
    assign flag_wr_enable = write_flag && (phase == ph_execute);

    // store address is the immediate, carried on target
    assign req_valid = (phase == ph_fetch) || (phase == ph_store);
    assign req_kind  = (phase == ph_store) ? cpu_bus_pkg::req_store : cpu_bus_pkg::req_fetch;
    assign req_addr  = (phase == ph_store) ? target : pc;
    assign req_wdata = store_data;

    assign halted = (phase == ph_halted);

    // a store transfer runs only for the executed store instruction
    a_store_after_execute: assert property (
        @(posedge clock) disable iff (reset)
        (phase == ph_store) |-> store_req
    )
    else
        $error("store phase without a store instruction");

    a_pc_aligned: assert property (
        @(posedge clock) disable iff (reset)
        pc[1:0] == 2'b00
    )
    else
        $error("program counter lost word alignment");

endmodule

`default_nettype wire

/* hw/cpu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_alu (
    input  wire cpu_isa_pkg::word_t instr,
    input  wire cpu_isa_pkg::word_t src_a,
    input  wire cpu_isa_pkg::word_t src_b,
    input  wire cpu_isa_pkg::flag_t flag_a,
    input  wire cpu_isa_pkg::flag_t flag_b,

    output cpu_isa_pkg::word_t result,
    output cpu_isa_pkg::flag_t result_flag,
    output logic               write_reg,
    output logic               write_flag,
    output logic               redirect,
    output cpu_isa_pkg::word_t target,
    output logic               store_req,
    output logic               halt_req
);

    cpu_isa_pkg::instr_t fields;

    assign fields = cpu_isa_pkg::instr_t'(instr);

    // branch, jump and store all take their address from the immediate
    assign target = cpu_isa_pkg::word_t'(fields.imm);

    always_comb
    begin
        result      = '0;
        // only seen by the bank when write_flag is set
        result_flag = flag_b;
        write_reg   = 1'b0;
        write_flag  = 1'b0;
        redirect    = 1'b0;
        store_req   = 1'b0;
        halt_req    = 1'b0;

        case (fields.opcode)
            cpu_isa_pkg::op_add,
            cpu_isa_pkg::op_sub,
            cpu_isa_pkg::op_and,
            cpu_isa_pkg::op_or,
            cpu_isa_pkg::op_xor:
            begin
                case (fields.opcode)
                    cpu_isa_pkg::op_add: result = src_a + src_b;
                    cpu_isa_pkg::op_sub: result = src_a - src_b;
                    cpu_isa_pkg::op_and: result = src_a & src_b;
                    cpu_isa_pkg::op_or:  result = src_a | src_b;
                    default:             result = src_a ^ src_b;
                endcase
                result_flag = (result == '0);
                write_reg   = 1'b1;
                write_flag  = 1'b1;
            end
            cpu_isa_pkg::op_ldi:
            begin
                // high form keeps the lower half of source a
                if (fields.high)
                    result = {fields.imm, src_a[`CPU_DATA_WIDTH-`CPU_IMM_WIDTH-1:0]};
                else
                    result = cpu_isa_pkg::word_t'(fields.imm);
                write_reg = 1'b1;
            end
            cpu_isa_pkg::op_cmpeq:
            begin
                result_flag = (src_a == src_b);
                write_flag  = 1'b1;
            end
            cpu_isa_pkg::op_branch: redirect  = flag_a;
            cpu_isa_pkg::op_jump:   redirect  = 1'b1;
            cpu_isa_pkg::op_store:  store_req = 1'b1;
            cpu_isa_pkg::op_halt:   halt_req  = 1'b1;
            // nop and unused encodings change nothing
            default:
            begin
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/cpu_state_bank.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_config.svh"

module cpu_state_bank #(
    parameter type entry_t = logic
) (
    input  wire                       clock,
    input  wire                       reset,

    input  wire cpu_isa_pkg::reg_index_t rd_index_a,
    output entry_t                    rd_data_a,

    input  wire cpu_isa_pkg::reg_index_t rd_index_b,
    output entry_t                    rd_data_b,

    input  wire                       wr_enable,
    input  wire cpu_isa_pkg::reg_index_t wr_index,
    input  wire entry_t               wr_data
);

    entry_t entries [`CPU_REG_COUNT];

    // one write per cycle, visible on the reads from the next cycle
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < `CPU_REG_COUNT; i++)
            begin
                entries[i] <= '0;
            end
        end
        else if (wr_enable)
        begin
            entries[wr_index] <= wr_data;
        end
    end

    assign rd_data_a = entries[rd_index_a];
    assign rd_data_b = entries[rd_index_b];

    // an unknown index would corrupt an unknown entry
    a_wr_index_known: assert property (
        @(posedge clock) disable iff (reset)
        wr_enable |-> !$isunknown(wr_index)
    )
    else
        $error("state bank write with unknown index");

endmodule

`default_nettype wire

/* hw/cpu_bus_pkg.sv */
`default_nettype none

package cpu_bus_pkg;

    // what the sequencer asks the bus for
    typedef enum logic {
        req_fetch,
        req_store
    } request_e;

    // apb transfer phases
    typedef enum logic [1:0] {
        apb_idle,
        apb_setup,
        apb_access
    } apb_phase_e;

endpackage

`default_nettype wire

/* hw/cpu_isa_pkg.sv */
`default_nettype none

`include "cpu_config.svh"

package cpu_isa_pkg;

    typedef logic [`CPU_DATA_WIDTH-1:0] word_t;
    typedef logic                       flag_t;

    // selects one of the registers and its flag
    typedef logic [$clog2(`CPU_REG_COUNT)-1:0] reg_index_t;

    typedef logic [`CPU_IMM_WIDTH-1:0] imm_t;

    // store stays at 7 so older programs still run
    typedef enum logic [5:0] {
        op_nop    = 6'd0,
        op_add    = 6'd1,
        op_sub    = 6'd2,
        op_and    = 6'd3,
        op_or     = 6'd4,
        op_xor    = 6'd5,
        op_ldi    = 6'd6,
        op_store  = 6'd7,
        op_cmpeq  = 6'd8,
        op_branch = 6'd9,
        op_jump   = 6'd10,
        op_halt   = 6'd11
    } opcode_e;

    // field layout, msb first
    typedef struct packed {
        imm_t       imm;
        logic       high;
        reg_index_t dest;
        reg_index_t src_b;
        reg_index_t src_a;
        opcode_e    opcode;
    } instr_t;

endpackage

`default_nettype wire

/* hw/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// width of registers, bus addresses and bus data
`define CPU_DATA_WIDTH 32

// general registers, and one flag per register
`define CPU_REG_COUNT 8

// address of the first instruction fetch
`define CPU_RESET_PC 'h0

// immediate field in the upper half of the instruction
`define CPU_IMM_WIDTH 16

`endif
